/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  typedef enum logic [2:0] {
    op_ldr  = 3'b011,
    op_str  = 3'b100,
    op_alu  = 3'b101,
    op_mov  = 3'b110,
    op_halt = 3'b111
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add   = 2'b00,
    alu_sub   = 2'b01,
    alu_and   = 2'b10,
    alu_not_b = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_none = 2'b00,
    sh_left = 2'b01,
    sh_lsr  = 2'b10,
    sh_asr  = 2'b11
  } shift_e;

  // register form
  typedef struct packed {
    opcode_e    opcode;
    alu_op_e    op;
    logic [2:0] rn;
    logic [2:0] rd;
    shift_e     sh;
    logic [2:0] rm;
  } instr_reg_t;

  // immediate form
  typedef struct packed {
    opcode_e    opcode;
    alu_op_e    op;
    logic [2:0] rn;
    logic [7:0] imm8;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_t;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  typedef enum logic [1:0] {
    sel_rm = 2'b00,
    sel_rd = 2'b01,
    sel_rn = 2'b10
  } reg_sel_e;

  typedef enum logic [1:0] {
    wb_c     = 2'b00,
    wb_pc    = 2'b01,
    wb_imm8  = 2'b10,
    wb_mdata = 2'b11
  } wb_sel_e;

  typedef struct packed {
    logic     w_en;
    logic     en_a;
    logic     en_b;
    logic     en_c;
    logic     en_status;
    logic     sel_a_zero;
    logic     sel_b_imm;
    reg_sel_e reg_sel;
    wb_sel_e  wb_sel;
  } dp_ctrl_t;

endpackage

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire logic [15:0]      val_a,
  input  wire logic [15:0]      val_b,
  input  wire cpu_pkg::alu_op_e op,
  output logic [15:0]           result,
  output cpu_pkg::flags_t       flags_next
);
  import cpu_pkg::*;

  logic ovf;

  always_comb begin
    ovf = 1'b0;
    case (op)
      alu_add: begin
        result = val_a + val_b;
        // same operand signs, result sign flipped
        ovf = (val_a[15] == val_b[15]) && (result[15] != val_a[15]);
      end
      alu_sub: begin
        result = val_a - val_b;
        ovf = (val_a[15] != val_b[15]) && (result[15] != val_a[15]);
      end
      alu_and: result = val_a & val_b;
      default: result = ~val_b;
    endcase
  end

  assign flags_next.z = (result == 16'd0);
  assign flags_next.n = result[15];
  assign flags_next.v = ovf;

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire logic        clk,
  input  wire logic        w_en,
  input  wire logic [2:0]  w_addr,
  input  wire logic [15:0] w_data,
  input  wire logic [2:0]  r_addr,
  output logic [15:0]      r_data
);

  logic [15:0] regs [8];

  always_ff @(posedge clk) begin
    if (w_en) begin
      regs[w_addr] <= w_data;
    end
  end

  // combinational read port
  assign r_data = regs[r_addr];

endmodule

`default_nettype wire

/* logic/idecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module idecoder (
  input  wire cpu_pkg::instr_t   ir,
  input  wire cpu_pkg::reg_sel_e reg_sel,
  output cpu_pkg::opcode_e       opcode,
  output cpu_pkg::alu_op_e       op,
  output cpu_pkg::shift_e        shift,
  output logic [2:0]             reg_addr,
  output logic [15:0]            sximm5,
  output logic [15:0]            sximm8
);
  import cpu_pkg::*;

  logic [4:0] imm5;
  logic       is_mem;

  assign opcode = ir.r.opcode;
  assign op     = ir.r.op;

  // imm5 overlaps sh and rm
  assign imm5   = {ir.r.sh, ir.r.rm};
  assign sximm5 = {{11{imm5[4]}}, imm5};
  assign sximm8 = {{8{ir.i.imm8[7]}}, ir.i.imm8};

  // ldr/str carry an offset where sh would be
  assign is_mem = (ir.r.opcode == op_ldr) || (ir.r.opcode == op_str);
  assign shift  = is_mem ? sh_none : ir.r.sh;

  always_comb begin
    case (reg_sel)
      sel_rm:  reg_addr = ir.r.rm;
      sel_rd:  reg_addr = ir.r.rd;
      default: reg_addr = ir.r.rn;
    endcase
  end

endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter int ADDR_W = 8
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire cpu_pkg::dp_ctrl_t ctrl,
  input  wire logic [2:0]        reg_addr,
  input  wire cpu_pkg::shift_e   shift,
  input  wire cpu_pkg::alu_op_e  alu_op,
  input  wire logic [15:0]       sximm5,
  input  wire logic [15:0]       sximm8,
  input  wire logic [ADDR_W-1:0] pc,
  input  wire logic [15:0]       mdata,
  output logic [15:0]            c_out,
  output cpu_pkg::flags_t        flags
);
  import cpu_pkg::*;

  logic [15:0] a_reg, b_reg, b_shifted;
  logic [15:0] val_a, val_b, alu_result;
  logic [15:0] r_data, w_data;
  flags_t      flags_next;

  regfile u_regfile (
    .clk    (clk),
    .w_en   (ctrl.w_en),
    .w_addr (reg_addr),
    .w_data (w_data),
    .r_addr (reg_addr),
    .r_data (r_data)
  );

  alu u_alu (
    .val_a      (val_a),
    .val_b      (val_b),
    .op         (alu_op),
    .result     (alu_result),
    .flags_next (flags_next)
  );

  always_comb begin
    case (shift)
      sh_left: b_shifted = b_reg << 1;
      sh_lsr:  b_shifted = b_reg >> 1;
      sh_asr:  b_shifted = $signed(b_reg) >>> 1;
      default: b_shifted = b_reg;
    endcase
  end

  assign val_a = ctrl.sel_a_zero ? 16'd0 : a_reg;
  assign val_b = ctrl.sel_b_imm ? sximm5 : b_shifted;

  always_comb begin
    case (ctrl.wb_sel)
      wb_pc:    w_data = 16'(pc);
      wb_imm8:  w_data = sximm8;
      wb_mdata: w_data = mdata;
      default:  w_data = c_out;
    endcase
  end

  // operand latches
  always_ff @(posedge clk) begin
    if (ctrl.en_a) begin
      a_reg <= r_data;
    end
    if (ctrl.en_b) begin
      b_reg <= r_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      c_out <= 16'd0;
      flags <= '0;
    end else begin
      if (ctrl.en_c) begin
        c_out <= alu_result;
      end
      if (ctrl.en_status) begin
        flags <= flags_next;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire cpu_pkg::opcode_e opcode,
  input  wire cpu_pkg::alu_op_e op,
  output cpu_pkg::dp_ctrl_t     ctrl,
  output logic                  load_pc,
  output logic                  clear_pc,
  output logic                  load_ir,
  output logic                  load_addr,
  output logic                  sel_pc_addr,
  output logic                  ram_w_en,
  output logic                  halted
);
  import cpu_pkg::*;

  typedef enum logic [4:0] {
    s_reset, s_wait1, s_wait2, s_fetch,
    s_movi, s_un1, s_un2, s_un3,
    s_ab1, s_ab2, s_cmp3, s_alu3, s_alu4,
    s_ls1, s_ls2, s_ldr3, s_ldr4, s_ldr5, s_str3, s_str4, s_str5,
    s_halt
  } state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= s_reset;
    end else begin
      case (state)
        s_reset: state <= s_wait1;
        s_wait1: state <= s_wait2;
        s_wait2: state <= s_fetch;
        s_fetch: begin
          case (opcode)
            // op 10 selects the immediate mov
            op_mov:  state <= (op == alu_and) ? s_movi : s_un1;
            op_alu: begin
              if (op == alu_not_b) state <= s_un1;
              else state <= s_ab1;
            end
            op_ldr, op_str: state <= s_ls1;
            op_halt: state <= s_halt;
            default: state <= s_wait1;
          endcase
        end
        s_un1:  state <= s_un2;
        s_un2:  state <= s_un3;
        s_ab1:  state <= s_ab2;
        s_ab2:  state <= (op == alu_sub) ? s_cmp3 : s_alu3;
        s_alu3: state <= s_alu4;
        s_ls1:  state <= s_ls2;
        s_ls2:  state <= (opcode == op_str) ? s_str3 : s_ldr3;
        s_ldr3: state <= s_ldr4;
        s_ldr4: state <= s_ldr5;
        s_str3: state <= s_str4;
        s_str4: state <= s_str5;
        s_halt: state <= s_halt;
        // last step of every instruction refetches
        default: state <= s_wait1;
      endcase
    end
  end

  always_comb begin
    ctrl        = '0;
    load_pc     = 1'b0;
    clear_pc    = 1'b0;
    load_ir     = 1'b0;
    load_addr   = 1'b0;
    sel_pc_addr = 1'b1;
    ram_w_en    = 1'b0;
    halted      = 1'b0;
    case (state)
      s_reset: begin
        load_pc  = 1'b1;
        clear_pc = 1'b1;
      end
      s_wait2: load_ir = 1'b1;
      s_fetch: begin
        load_ir = 1'b1;
        load_pc = 1'b1;
      end
      s_movi: begin
        ctrl.reg_sel = sel_rn;
        ctrl.wb_sel  = wb_imm8;
        ctrl.w_en    = 1'b1;
      end
      s_un1: ctrl.en_b = 1'b1;
      s_un2, s_str4: begin
        ctrl.sel_a_zero = 1'b1;
        ctrl.en_c       = 1'b1;
      end
      s_un3, s_alu4: begin
        ctrl.reg_sel = sel_rd;
        ctrl.w_en    = 1'b1;
      end
      s_ab1, s_ls1: begin
        ctrl.reg_sel = sel_rn;
        ctrl.en_a    = 1'b1;
      end
      s_ab2:  ctrl.en_b = 1'b1;
      s_cmp3: ctrl.en_status = 1'b1;
      s_alu3: ctrl.en_c = 1'b1;
      s_ls2: begin
        ctrl.sel_b_imm = 1'b1;
        ctrl.en_c      = 1'b1;
      end
      s_ldr3: load_addr = 1'b1;
      s_ldr4: sel_pc_addr = 1'b0;
      s_ldr5: begin
        sel_pc_addr  = 1'b0;
        ctrl.reg_sel = sel_rd;
        ctrl.wb_sel  = wb_mdata;
        ctrl.w_en    = 1'b1;
      end
      // address goes out while Rd heads for B
      s_str3: begin
        load_addr    = 1'b1;
        ctrl.reg_sel = sel_rd;
        ctrl.en_b    = 1'b1;
      end
      s_str5: begin
        sel_pc_addr = 1'b0;
        ram_w_en    = 1'b1;
      end
      s_halt: halted = 1'b1;
      default: ;
    endcase
  end

  // register file and RAM never written together
  assert property (@(posedge clk) disable iff (!rst_n) !(ram_w_en && ctrl.w_en));

  // halted is sticky until reset
  assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted);

endmodule

`default_nettype wire

/* logic/ram.sv */
`timescale 1ns/1ps
`default_nettype none

module ram #(
  parameter int ADDR_W = 8
) (
  input  wire logic              clk,
  input  wire logic              w_en,
  input  wire logic [ADDR_W-1:0] addr,
  input  wire logic [15:0]       w_data,
  output logic [15:0]            r_data
);

  logic [15:0] mem [2**ADDR_W];

  // write-first, read data one cycle later
  always_ff @(posedge clk) begin
    if (w_en) begin
      mem[addr] <= w_data;
      r_data    <= w_data;
    end else begin
      r_data <= mem[addr];
    end
  end

  assert property (@(posedge clk) w_en |-> !$isunknown(addr));

endmodule

`default_nettype wire

/* logic/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter int ADDR_W = 8
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic [ADDR_W-1:0] start_pc,
  input  wire logic [15:0]       mem_r_data,
  output logic [ADDR_W-1:0]      mem_addr,
  output logic                   mem_w_en,
  output logic [15:0]            mem_w_data,
  output logic [15:0]            out,
  output cpu_pkg::flags_t        flags,
  output logic                   halted
);
  import cpu_pkg::*;

  logic [ADDR_W-1:0] pc, data_addr;
  instr_t            ir;
  dp_ctrl_t          ctrl;
  opcode_e           opcode;
  alu_op_e           op;
  shift_e            shift;
  logic [2:0]        reg_addr;
  logic [15:0]       sximm5, sximm8, c_out;
  logic              load_pc, clear_pc, load_ir, load_addr, sel_pc_addr, ram_w_en;

  idecoder u_idecoder (
    .ir       (ir),
    .reg_sel  (ctrl.reg_sel),
    .opcode   (opcode),
    .op       (op),
    .shift    (shift),
    .reg_addr (reg_addr),
    .sximm5   (sximm5),
    .sximm8   (sximm8)
  );

  datapath #(.ADDR_W(ADDR_W)) u_datapath (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .reg_addr (reg_addr),
    .shift    (shift),
    .alu_op   (op),
    .sximm5   (sximm5),
    .sximm8   (sximm8),
    .pc       (pc),
    .mdata    (mem_r_data),
    .c_out    (c_out),
    .flags    (flags)
  );

  controller u_controller (
    .clk         (clk),
    .rst_n       (rst_n),
    .opcode      (opcode),
    .op          (op),
    .ctrl        (ctrl),
    .load_pc     (load_pc),
    .clear_pc    (clear_pc),
    .load_ir     (load_ir),
    .load_addr   (load_addr),
    .sel_pc_addr (sel_pc_addr),
    .ram_w_en    (ram_w_en),
    .halted      (halted)
  );

  // pc, instruction and data address registers
  always_ff @(posedge clk) begin
    if (load_pc) begin
      pc <= clear_pc ? start_pc : pc + 1'b1;
    end
    if (load_ir) begin
      ir <= mem_r_data;
    end
    if (load_addr) begin
      data_addr <= c_out[ADDR_W-1:0];
    end
  end

  assign mem_addr   = sel_pc_addr ? pc : data_addr;
  assign mem_w_en   = ram_w_en;
  assign mem_w_data = c_out;
  assign out        = c_out;

endmodule

`default_nettype wire

/* logic/simple_computer.sv */
`timescale 1ns/1ps
`default_nettype none

module simple_computer #(
  parameter int ADDR_W = 8
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic [ADDR_W-1:0] start_pc,
  input  wire logic              boot_we,
  input  wire logic [ADDR_W-1:0] boot_addr,
  input  wire logic [15:0]       boot_data,
  output logic [15:0]            out,
  output cpu_pkg::flags_t        flags,
  output logic                   halted
);

  logic [ADDR_W-1:0] cpu_addr, ram_addr;
  logic [15:0]       cpu_w_data, ram_w_data, ram_r_data;
  logic              cpu_w_en, ram_w_en;

  cpu #(.ADDR_W(ADDR_W)) u_cpu (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_pc   (start_pc),
    .mem_r_data (ram_r_data),
    .mem_addr   (cpu_addr),
    .mem_w_en   (cpu_w_en),
    .mem_w_data (cpu_w_data),
    .out        (out),
    .flags      (flags),
    .halted     (halted)
  );

  // boot port owns the RAM while the core is in reset
  assign ram_w_en   = rst_n ? cpu_w_en : boot_we;
  assign ram_addr   = rst_n ? cpu_addr : boot_addr;
  assign ram_w_data = rst_n ? cpu_w_data : boot_data;

  ram #(.ADDR_W(ADDR_W)) u_ram (
    .clk    (clk),
    .w_en   (ram_w_en),
    .addr   (ram_addr),
    .w_data (ram_w_data),
    .r_data (ram_r_data)
  );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

/* tests/simple_computer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module simple_computer_tb;
  import cpu_pkg::*;

  localparam int ADDR_W = 8;
  localparam int CYCLES_PER_TEST = 200;
  localparam logic [15:0] HALT_WORD = 16'he000;

  typedef struct packed {
    logic [ADDR_W-1:0] start;
    logic [7:0][15:0]  prog;
    logic [ADDR_W-1:0] data_addr;
    logic [15:0]       data_word;
    logic [15:0]       exp_out;
    flags_t            exp_flags;
    logic [7:0]        reset_at;
  } test_t;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] start_pc;
  logic              boot_we;
  logic [ADDR_W-1:0] boot_addr;
  logic [15:0]       boot_data;
  logic [15:0]       out;
  flags_t            flags;
  logic              halted;

  test_t       tests [$];
  string       names [$];
  logic [15:0] prog_q [$];
  int          cycles;
  int          cycle_limit;

  tb_clock u_tb_clock (
    .clk (clk)
  );

  simple_computer #(.ADDR_W(ADDR_W)) u_simple_computer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_pc  (start_pc),
    .boot_we   (boot_we),
    .boot_addr (boot_addr),
    .boot_data (boot_data),
    .out       (out),
    .flags     (flags),
    .halted    (halted)
  );

  // instruction encoders, fields from the ISA layout
  function automatic logic [15:0] mov_imm(input logic [2:0] rn, input logic [7:0] imm8);
    return {op_mov, 2'b10, rn, imm8};
  endfunction

  function automatic logic [15:0] mov_reg(input logic [2:0] rd, input logic [2:0] rm,
                                          input logic [1:0] sh);
    return {op_mov, 2'b00, 3'd0, rd, sh, rm};
  endfunction

  function automatic logic [15:0] alu_reg(input logic [1:0] op, input logic [2:0] rd,
                                          input logic [2:0] rn, input logic [2:0] rm,
                                          input logic [1:0] sh);
    return {op_alu, op, rn, rd, sh, rm};
  endfunction

  function automatic logic [15:0] mem_off(input logic [2:0] opc, input logic [2:0] rd,
                                          input logic [2:0] rn, input logic [4:0] imm5);
    return {opc, 2'b00, rn, rd, imm5};
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic boot_write(input logic [ADDR_W-1:0] addr, input logic [15:0] data);
    boot_we   = 1'b1;
    boot_addr = addr;
    boot_data = data;
    next_cycle();
  endtask

  task automatic add_test(input string name, input logic [ADDR_W-1:0] start,
                          input logic [ADDR_W-1:0] d_addr, input logic [15:0] d_word,
                          input logic [15:0] exp_out, input logic [2:0] exp_flags,
                          input int reset_at);
    test_t t;
    t.start     = start;
    t.data_addr = d_addr;
    t.data_word = d_word;
    t.exp_out   = exp_out;
    t.exp_flags = exp_flags;
    t.reset_at  = 8'(reset_at);
    for (int i = 0; i < 8; i++) begin
      t.prog[i] = (i < prog_q.size()) ? prog_q[i] : HALT_WORD;
    end
    tests.push_back(t);
    names.push_back(name);
    prog_q.delete();
  endtask

  // 0x35 + (0x0f << 1) = 0x53, & 0x0f = 0x03, ~0x03 = 0xfffc
  task automatic push_arith_program();
    prog_q.push_back(mov_imm(3'd0, 8'h35));
    prog_q.push_back(mov_imm(3'd1, 8'h0f));
    prog_q.push_back(alu_reg(alu_add, 3'd2, 3'd0, 3'd1, sh_left));
    prog_q.push_back(alu_reg(alu_and, 3'd3, 3'd2, 3'd1, sh_none));
    prog_q.push_back(alu_reg(alu_not_b, 3'd4, 3'd0, 3'd3, sh_none));
  endtask

  // expected flags are {z, n, v}
  task automatic build_table();
    // 0xffa3 << 1 = 0xff46, << 1 = 0xfe8c, then >>> 1 = 0xff46
    prog_q.push_back(mov_imm(3'd0, 8'ha3));
    prog_q.push_back(mov_reg(3'd1, 3'd0, sh_left));
    prog_q.push_back(mov_reg(3'd2, 3'd1, sh_left));
    prog_q.push_back(mov_reg(3'd3, 3'd2, sh_asr));
    add_test("move and shift", 8'h00, 8'hf0, 16'h0000, 16'hff46, 3'b000, 0);
    push_arith_program();
    add_test("add and mvn", 8'h00, 8'hf0, 16'h0000, 16'hfffc, 3'b000, 0);
    // 7 - 7 = 0
    prog_q.push_back(mov_imm(3'd0, 8'h07));
    prog_q.push_back(mov_imm(3'd1, 8'h07));
    prog_q.push_back(mov_reg(3'd2, 3'd1, sh_none));
    prog_q.push_back(alu_reg(alu_sub, 3'd0, 3'd0, 3'd1, sh_none));
    add_test("cmp equal", 8'h00, 8'hf0, 16'h0000, 16'h0007, 3'b100, 0);
    // 3 - 5 = -2
    prog_q.push_back(mov_imm(3'd0, 8'h03));
    prog_q.push_back(mov_imm(3'd1, 8'h05));
    prog_q.push_back(mov_reg(3'd2, 3'd0, sh_none));
    prog_q.push_back(alu_reg(alu_sub, 3'd0, 3'd0, 3'd1, sh_none));
    add_test("cmp negative", 8'h00, 8'hf0, 16'h0000, 16'h0003, 3'b010, 0);
    // 0x7fff - 0xffff = 0x8000 overflows
    prog_q.push_back(mov_imm(3'd0, 8'hff));
    prog_q.push_back(mov_reg(3'd1, 3'd0, sh_lsr));
    prog_q.push_back(alu_reg(alu_sub, 3'd0, 3'd1, 3'd0, sh_none));
    add_test("cmp overflow", 8'h00, 8'hf0, 16'h0000, 16'h7fff, 3'b011, 0);
    // 0x3c + 4 = 0x40
    prog_q.push_back(mov_imm(3'd0, 8'h3c));
    prog_q.push_back(mem_off(op_ldr, 3'd1, 3'd0, 5'd4));
    prog_q.push_back(mov_reg(3'd2, 3'd1, sh_none));
    add_test("load", 8'h00, 8'h40, 16'hbeef, 16'hbeef, 3'b000, 0);
    // load 0x50, store its complement at 0x55, load it back
    prog_q.push_back(mov_imm(3'd0, 8'h52));
    prog_q.push_back(mem_off(op_ldr, 3'd1, 3'd0, 5'b11110));
    prog_q.push_back(alu_reg(alu_not_b, 3'd2, 3'd0, 3'd1, sh_none));
    prog_q.push_back(mem_off(op_str, 3'd2, 3'd0, 5'd3));
    prog_q.push_back(mem_off(op_ldr, 3'd3, 3'd0, 5'd3));
    prog_q.push_back(mov_reg(3'd4, 3'd3, sh_none));
    add_test("store and reload", 8'h00, 8'h50, 16'h1234, 16'hedcb, 3'b000, 0);
    push_arith_program();
    add_test("restart at start_pc", 8'h80, 8'hf0, 16'h0000, 16'hfffc, 3'b000, 12);
  endtask

  task automatic run_entry(input int k);
    test_t t;
    t        = tests[k];
    rst_n    = 1'b0;
    start_pc = t.start;
    for (int i = 0; i < 8; i++) begin
      boot_write(t.start + ADDR_W'(i), t.prog[i]);
    end
    boot_write(t.data_addr, t.data_word);
    boot_we = 1'b0;
    repeat (2) next_cycle();
    rst_n = 1'b1;
    assert (halted === 1'b0)
      else abort_run($sformatf("[FAIL] %0t: %s: halted high after reset", $time, names[k]));
    // reset again part way through the program
    if (t.reset_at != 0) begin
      repeat (t.reset_at) next_cycle();
      rst_n = 1'b0;
      repeat (2) next_cycle();
      rst_n = 1'b1;
    end
    while (halted !== 1'b1) begin
      next_cycle();
    end
    assert (out === t.exp_out)
      else abort_run($sformatf("[FAIL] %0t: %s: out = %h, expected %h",
                               $time, names[k], out, t.exp_out));
    assert (flags === t.exp_flags)
      else abort_run($sformatf("[FAIL] %0t: %s: flags = %b, expected %b",
                               $time, names[k], flags, t.exp_flags));
    repeat (3) next_cycle();
    assert (halted === 1'b1 && out === t.exp_out && flags === t.exp_flags)
      else abort_run($sformatf("[FAIL] %0t: %s: outputs changed after halt",
                               $time, names[k]));
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      abort_run($sformatf("timeout: the programs did not all halt within %0d cycles",
                          cycle_limit));
    end
  end

  initial begin
    rst_n       = 1'b0;
    start_pc    = '0;
    boot_we     = 1'b0;
    boot_addr   = '0;
    boot_data   = 16'h0000;
    cycles      = 0;
    cycle_limit = 0;
    build_table();
    cycle_limit = CYCLES_PER_TEST * tests.size();
    repeat (2) next_cycle();
    for (int k = 0; k < tests.size(); k++) begin
      run_entry(k);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/cpu_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/idecoder.sv
logic/datapath.sv
logic/controller.sv
logic/ram.sv
logic/cpu.sv
logic/simple_computer.sv
tests/tb_clock.sv
tests/simple_computer_tb.sv
